// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

	//////////////////////////////////////////////////
	// widths

	localparam int unsigned xlen       = 32; // data word
	localparam int unsigned reg_addr_w = 5;  // gpr index
	localparam int unsigned aluop_w    = 8;
	localparam int unsigned alusel_w   = 3;
	localparam int unsigned exc_code_w = 5;

	//////////////////////////////////////////////////
	// operation codes, one per kept mnemonic

	// logic
	localparam logic [aluop_w-1:0] aluop_and   = 8'b0010_0100;
	localparam logic [aluop_w-1:0] aluop_or    = 8'b0010_0101;
	localparam logic [aluop_w-1:0] aluop_xor   = 8'b0010_0110;
	localparam logic [aluop_w-1:0] aluop_nor   = 8'b0010_0111;
	localparam logic [aluop_w-1:0] aluop_andi  = 8'b0101_1001;
	localparam logic [aluop_w-1:0] aluop_ori   = 8'b0101_1010;
	localparam logic [aluop_w-1:0] aluop_xori  = 8'b0101_1011;
	localparam logic [aluop_w-1:0] aluop_lui   = 8'b0101_1100;
	// shifts
	localparam logic [aluop_w-1:0] aluop_sll   = 8'b0111_1100;
	localparam logic [aluop_w-1:0] aluop_srl   = 8'b0000_0010;
	localparam logic [aluop_w-1:0] aluop_sra   = 8'b0000_0011;
	localparam logic [aluop_w-1:0] aluop_sllv  = 8'b0000_0100;
	localparam logic [aluop_w-1:0] aluop_srlv  = 8'b0000_0110;
	localparam logic [aluop_w-1:0] aluop_srav  = 8'b0000_0111;
	// hi/lo moves
	localparam logic [aluop_w-1:0] aluop_mfhi  = 8'b0001_0000;
	localparam logic [aluop_w-1:0] aluop_mthi  = 8'b0001_0001;
	localparam logic [aluop_w-1:0] aluop_mflo  = 8'b0001_0010;
	localparam logic [aluop_w-1:0] aluop_mtlo  = 8'b0001_0011;
	// arithmetic
	localparam logic [aluop_w-1:0] aluop_add   = 8'b0010_0000;
	localparam logic [aluop_w-1:0] aluop_addu  = 8'b0010_0001;
	localparam logic [aluop_w-1:0] aluop_sub   = 8'b0010_0010;
	localparam logic [aluop_w-1:0] aluop_subu  = 8'b0010_0011;
	localparam logic [aluop_w-1:0] aluop_slt   = 8'b0010_1010;
	localparam logic [aluop_w-1:0] aluop_sltu  = 8'b0010_1011;
	localparam logic [aluop_w-1:0] aluop_addi  = 8'b0101_0101;
	localparam logic [aluop_w-1:0] aluop_addiu = 8'b0101_0110;
	localparam logic [aluop_w-1:0] aluop_slti  = 8'b0101_0111;
	localparam logic [aluop_w-1:0] aluop_sltiu = 8'b0101_1000;
	localparam logic [aluop_w-1:0] aluop_mult  = 8'b0001_1000;
	localparam logic [aluop_w-1:0] aluop_multu = 8'b0001_1001;
	localparam logic [aluop_w-1:0] aluop_div   = 8'b0001_1010;
	localparam logic [aluop_w-1:0] aluop_divu  = 8'b0001_1011;

	// result classes
	localparam logic [alusel_w-1:0] alusel_logic  = 3'b001;
	localparam logic [alusel_w-1:0] alusel_shift  = 3'b010;
	localparam logic [alusel_w-1:0] alusel_move   = 3'b011;
	localparam logic [alusel_w-1:0] alusel_arith  = 3'b100;
	localparam logic [alusel_w-1:0] alusel_branch = 3'b110;
	localparam logic [alusel_w-1:0] alusel_mem    = 3'b111;

	localparam logic [exc_code_w-1:0] ec_none = 5'h1f; // no exception pending
	localparam logic [exc_code_w-1:0] ec_ov   = 5'h0c; // arithmetic overflow

	//////////////////////////////////////////////////
	// instruction word, r-type and i-type views

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r_fmt;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i_fmt;
	} inst_u;

endpackage

`default_nettype wire

// File: ex_logic_shift.sv
`timescale 1ns/1ps
`default_nettype none

module ex_logic_shift (
	input  logic [ex_pkg::aluop_w-1:0] aluop_i,
	input  ex_pkg::inst_u              inst_i,
	input  logic [ex_pkg::xlen-1:0]    reg1_i, // rs
	input  logic [ex_pkg::xlen-1:0]    reg2_i, // rt, or the placed immediate
	output logic [ex_pkg::xlen-1:0]    logic_res_o,
	output logic [ex_pkg::xlen-1:0]    shift_res_o
);
	import ex_pkg::*;

	logic       fixed_sa; // shamt field vs rs
	logic [4:0] sa;

	// bitwise ops, immediates already sit in reg2_i
	always_comb begin
		case (aluop_i)
			aluop_and, aluop_andi: logic_res_o = reg1_i & reg2_i;
			aluop_or, aluop_ori:   logic_res_o = reg1_i | reg2_i;
			aluop_xor, aluop_xori: logic_res_o = reg1_i ^ reg2_i;
			aluop_nor:             logic_res_o = ~(reg1_i | reg2_i);
			aluop_lui:             logic_res_o = {inst_i.i_fmt.imm, 16'b0};
			default:               logic_res_o = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// shifter, always moves rt

	assign fixed_sa = (aluop_i == aluop_sll) || (aluop_i == aluop_srl)
		|| (aluop_i == aluop_sra);
	assign sa = fixed_sa ? inst_i.r_fmt.shamt : reg1_i[4:0]; // variable form uses rs[4:0]

	always_comb begin
		case (aluop_i)
			aluop_sll, aluop_sllv: shift_res_o = reg2_i << sa;
			aluop_srl, aluop_srlv: shift_res_o = reg2_i >> sa;
			// arithmetic, sign fill
			aluop_sra, aluop_srav: shift_res_o = $signed(reg2_i) >>> sa;
			default:               shift_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: ex_arith.sv
`timescale 1ns/1ps
`default_nettype none

module ex_arith (
	input  logic [ex_pkg::aluop_w-1:0] aluop_i,
	input  logic [ex_pkg::xlen-1:0]    reg1_i,
	input  logic [ex_pkg::xlen-1:0]    reg2_i,
	output logic [ex_pkg::xlen-1:0]    arith_res_o,
	output logic [2*ex_pkg::xlen-1:0]  prod_o,
	output logic                       ovf_o
);
	import ex_pkg::*;

	logic [xlen:0]     sum_x;  // 33 bit, sign extended
	logic [xlen:0]     diff_x;
	logic              lt_s;
	logic              lt_u;
	logic              mul_s;  // signed multiply
	logic [2*xlen-1:0] mul_a;
	logic [2*xlen-1:0] mul_b;

	assign sum_x  = {reg1_i[xlen-1], reg1_i} + {reg2_i[xlen-1], reg2_i};
	assign diff_x = {reg1_i[xlen-1], reg1_i} - {reg2_i[xlen-1], reg2_i};
	assign lt_s   = $signed(reg1_i) < $signed(reg2_i);
	assign lt_u   = reg1_i < reg2_i;

	always_comb begin
		case (aluop_i)
			aluop_add, aluop_addi, aluop_addu, aluop_addiu: arith_res_o = sum_x[xlen-1:0];
			aluop_sub, aluop_subu:                          arith_res_o = diff_x[xlen-1:0];
			aluop_slt, aluop_slti:   arith_res_o = {{(xlen-1){1'b0}}, lt_s};
			aluop_sltu, aluop_sltiu: arith_res_o = {{(xlen-1){1'b0}}, lt_u};
			default:                 arith_res_o = '0;
		endcase
	end

	// trapping forms only, top two bits of the 33 bit result disagree
	always_comb begin
		case (aluop_i)
			aluop_add, aluop_addi: ovf_o = sum_x[xlen] ^ sum_x[xlen-1];
			aluop_sub:             ovf_o = diff_x[xlen] ^ diff_x[xlen-1];
			default:               ovf_o = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// one 64 bit multiplier for both signednesses

	assign mul_s = (aluop_i == aluop_mult);
	// low 64 bits of the extended product are the true signed product
	assign mul_a = {{xlen{mul_s & reg1_i[xlen-1]}}, reg1_i};
	assign mul_b = {{xlen{mul_s & reg2_i[xlen-1]}}, reg2_i};
	assign prod_o = mul_a * mul_b; // hi:lo

endmodule

`default_nettype wire

// File: ex_divider.sv
`timescale 1ns/1ps
`default_nettype none

module ex_divider (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic [ex_pkg::aluop_w-1:0] aluop_i,
	input  logic [ex_pkg::xlen-1:0]    reg1_i, // dividend
	input  logic [ex_pkg::xlen-1:0]    reg2_i, // divisor, never zero
	output logic [2*ex_pkg::xlen-1:0]  div_res_o, // {rem, quo}
	output logic                       div_ready_o,
	output logic                       stall_o
);
	import ex_pkg::*;

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_busy = 2'd1;
	localparam logic [1:0] st_done = 2'd2;

	logic [1:0]      state;
	logic [4:0]      step;    // 32 steps, wraps at the end
	logic            is_div;
	logic            is_signed;
	logic [xlen-1:0] mag_a;
	logic [xlen-1:0] mag_b;
	logic [xlen-1:0] quo;     // dividend shifts out, quotient shifts in
	logic [xlen-1:0] rem;     // partial remainder
	logic [xlen-1:0] dvs;     // divisor magnitude
	logic            neg_q;
	logic            neg_r;
	logic [xlen:0]   trial;

	assign is_div    = (aluop_i == aluop_div) || (aluop_i == aluop_divu);
	assign is_signed = (aluop_i == aluop_div);

	// operand magnitudes, only DIV looks at the sign
	assign mag_a = (is_signed && reg1_i[xlen-1]) ? -reg1_i : reg1_i;
	assign mag_b = (is_signed && reg2_i[xlen-1]) ? -reg2_i : reg2_i;

	assign trial = {rem, quo[xlen-1]} - {1'b0, dvs};

	//////////////////////////////////////////////////
	// control

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= st_idle;
			step  <= '0;
		end else begin
			case (state)
				st_idle: begin
					step <= '0;
					if (is_div) state <= st_busy;
				end
				st_busy: begin
					step <= step + 5'd1;
					if (step == 5'd31) state <= st_done; // last restoring step
				end
				default: state <= st_idle; // done lasts one cycle
			endcase
		end
	end

	// datapath, one restoring step per busy cycle
	always_ff @(posedge clk) begin
		if (state == st_idle && is_div) begin
			quo   <= mag_a;
			rem   <= '0;
			dvs   <= mag_b;
			neg_q <= is_signed & (reg1_i[xlen-1] ^ reg2_i[xlen-1]);
			neg_r <= is_signed & reg1_i[xlen-1]; // remainder follows dividend
		end else if (state == st_busy) begin
			if (!trial[xlen]) begin
				rem <= trial[xlen-1:0]; // divisor fits
				quo <= {quo[xlen-2:0], 1'b1};
			end else begin
				rem <= {rem[xlen-2:0], quo[xlen-1]}; // restore
				quo <= {quo[xlen-2:0], 1'b0};
			end
		end
	end

	assign div_res_o   = {neg_r ? -rem : rem, neg_q ? -quo : quo};
	assign div_ready_o = (state == st_done);
	assign stall_o     = is_div && (state != st_done); // hold pipe until result

endmodule

`default_nettype wire

// File: ex_hilo.sv
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
	input  logic [ex_pkg::aluop_w-1:0] aluop_i,
	input  logic [ex_pkg::xlen-1:0]    reg1_i,
	input  logic [ex_pkg::xlen-1:0]    hi_i,
	input  logic [ex_pkg::xlen-1:0]    lo_i,
	input  logic                       mem_whilo_i,
	input  logic [ex_pkg::xlen-1:0]    mem_hi_i,
	input  logic [ex_pkg::xlen-1:0]    mem_lo_i,
	input  logic                       wb_whilo_i,
	input  logic [ex_pkg::xlen-1:0]    wb_hi_i,
	input  logic [ex_pkg::xlen-1:0]    wb_lo_i,
	input  logic [2*ex_pkg::xlen-1:0]  prod_i,
	input  logic [2*ex_pkg::xlen-1:0]  div_res_i,
	input  logic                       div_ready_i,
	output logic [ex_pkg::xlen-1:0]    move_res_o,
	output logic                       whilo_o,
	output logic [ex_pkg::xlen-1:0]    hi_o,
	output logic [ex_pkg::xlen-1:0]    lo_o
);
	import ex_pkg::*;

	logic [xlen-1:0] hi_fwd;
	logic [xlen-1:0] lo_fwd;

	// newest hi/lo, mem stage wins over wb
	assign hi_fwd = mem_whilo_i ? mem_hi_i : (wb_whilo_i ? wb_hi_i : hi_i);
	assign lo_fwd = mem_whilo_i ? mem_lo_i : (wb_whilo_i ? wb_lo_i : lo_i);

	always_comb begin
		case (aluop_i)
			aluop_mfhi: move_res_o = hi_fwd;
			aluop_mflo: move_res_o = lo_fwd;
			default:    move_res_o = '0;
		endcase
	end

	// write request to hi/lo
	always_comb begin
		whilo_o      = 1'b1;
		{hi_o, lo_o} = '0;
		case (aluop_i)
			aluop_mult, aluop_multu: {hi_o, lo_o} = prod_i;
			aluop_mthi:              {hi_o, lo_o} = {reg1_i, lo_fwd}; // lo kept
			aluop_mtlo:              {hi_o, lo_o} = {hi_fwd, reg1_i};
			aluop_div, aluop_divu: begin
				{hi_o, lo_o} = div_res_i;
				whilo_o      = div_ready_i; // only once the quotient is there
			end
			default:                 whilo_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: ex_result_sel.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result_sel (
	input  logic [ex_pkg::alusel_w-1:0]   alusel_i,
	input  ex_pkg::inst_u                 inst_i,
	input  logic [ex_pkg::xlen-1:0]       reg1_i,  // base register
	input  logic [ex_pkg::xlen-1:0]       pc_i,
	input  logic [ex_pkg::reg_addr_w-1:0] wd_i,
	input  logic                          wreg_i,
	input  logic                          in_delay_i,
	input  logic [ex_pkg::xlen-1:0]       link_addr_i,
	input  logic [ex_pkg::exc_code_w-1:0] exc_code_i,
	input  logic [ex_pkg::xlen-1:0]       exc_epc_i,
	input  logic [ex_pkg::xlen-1:0]       logic_res_i,
	input  logic [ex_pkg::xlen-1:0]       shift_res_i,
	input  logic [ex_pkg::xlen-1:0]       move_res_i,
	input  logic [ex_pkg::xlen-1:0]       arith_res_i,
	input  logic                          ovf_i,
	output logic [ex_pkg::xlen-1:0]       wdata_o,
	output logic                          wreg_o,
	output logic [ex_pkg::reg_addr_w-1:0] wd_o,
	output logic [ex_pkg::xlen-1:0]       mem_addr_o,
	output logic [ex_pkg::exc_code_w-1:0] exc_code_o,
	output logic [ex_pkg::xlen-1:0]       exc_epc_o
);
	import ex_pkg::*;

	logic [xlen-1:0] imm_sx; // sign extended offset

	always_comb begin
		case (alusel_i)
			alusel_logic:  wdata_o = logic_res_i;
			alusel_shift:  wdata_o = shift_res_i;
			alusel_move:   wdata_o = move_res_i;
			alusel_arith:  wdata_o = arith_res_i;
			alusel_branch: wdata_o = link_addr_i; // return address
			default:       wdata_o = '0;
		endcase
	end

	assign imm_sx     = {{(xlen-16){inst_i.i_fmt.imm[15]}}, inst_i.i_fmt.imm};
	assign mem_addr_o = (alusel_i == alusel_mem) ? reg1_i + imm_sx : '0;

	// overflow kills the write and takes over the exception fields
	assign wd_o       = wd_i;
	assign wreg_o     = wreg_i & ~ovf_i;
	assign exc_code_o = ovf_i ? ec_ov : exc_code_i;
	// epc points at the branch when in a delay slot
	assign exc_epc_o  = !ovf_i ? exc_epc_i : (in_delay_i ? pc_i - xlen'(4) : pc_i);

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic [ex_pkg::alusel_w-1:0]   alusel_i,
	input  logic [ex_pkg::aluop_w-1:0]    aluop_i,
	input  ex_pkg::inst_u                 inst_i,
	input  logic [ex_pkg::xlen-1:0]       reg1_i,
	input  logic [ex_pkg::xlen-1:0]       reg2_i,
	input  logic [ex_pkg::xlen-1:0]       pc_i,
	input  logic [ex_pkg::reg_addr_w-1:0] wd_i,
	input  logic                          wreg_i,
	input  logic                          in_delay_i,
	input  logic [ex_pkg::xlen-1:0]       link_addr_i,
	// hi/lo file and forwarding
	input  logic [ex_pkg::xlen-1:0]       hi_i,
	input  logic [ex_pkg::xlen-1:0]       lo_i,
	input  logic                          mem_whilo_i,
	input  logic [ex_pkg::xlen-1:0]       mem_hi_i,
	input  logic [ex_pkg::xlen-1:0]       mem_lo_i,
	input  logic                          wb_whilo_i,
	input  logic [ex_pkg::xlen-1:0]       wb_hi_i,
	input  logic [ex_pkg::xlen-1:0]       wb_lo_i,
	input  logic [ex_pkg::exc_code_w-1:0] exc_code_i,
	input  logic [ex_pkg::xlen-1:0]       exc_epc_i,
	output logic [ex_pkg::reg_addr_w-1:0] wd_o,
	output logic                          wreg_o,
	output logic [ex_pkg::xlen-1:0]       wdata_o,
	output logic                          whilo_o,
	output logic [ex_pkg::xlen-1:0]       hi_o,
	output logic [ex_pkg::xlen-1:0]       lo_o,
	output logic [ex_pkg::xlen-1:0]       mem_addr_o,
	output logic [ex_pkg::exc_code_w-1:0] exc_code_o,
	output logic [ex_pkg::xlen-1:0]       exc_epc_o,
	output logic                          stall_o
);
	import ex_pkg::*;

	logic [xlen-1:0]   logic_res;
	logic [xlen-1:0]   shift_res;
	logic [xlen-1:0]   move_res;
	logic [xlen-1:0]   arith_res;
	logic [2*xlen-1:0] prod;
	logic              ovf;
	logic [2*xlen-1:0] div_res;
	logic              div_ready;

	//////////////////////////////////////////////////
	// units

	ex_logic_shift u_logic_shift (.aluop_i, .inst_i, .reg1_i, .reg2_i,
		.logic_res_o(logic_res), .shift_res_o(shift_res));

	ex_arith u_arith (.aluop_i, .reg1_i, .reg2_i,
		.arith_res_o(arith_res), .prod_o(prod), .ovf_o(ovf));

	ex_divider u_divider (.clk, .rst_n_i, .aluop_i, .reg1_i, .reg2_i,
		.div_res_o(div_res), .div_ready_o(div_ready), .stall_o);

	ex_hilo u_hilo (.aluop_i, .reg1_i, .hi_i, .lo_i,
		.mem_whilo_i, .mem_hi_i, .mem_lo_i, .wb_whilo_i, .wb_hi_i, .wb_lo_i,
		.prod_i(prod), .div_res_i(div_res), .div_ready_i(div_ready),
		.move_res_o(move_res), .whilo_o, .hi_o, .lo_o);

	ex_result_sel u_result_sel (.alusel_i, .inst_i, .reg1_i, .pc_i, .wd_i, .wreg_i,
		.in_delay_i, .link_addr_i, .exc_code_i, .exc_epc_i,
		.logic_res_i(logic_res), .shift_res_i(shift_res),
		.move_res_i(move_res), .arith_res_i(arith_res), .ovf_i(ovf),
		.wdata_o, .wreg_o, .wd_o, .mem_addr_o, .exc_code_o, .exc_epc_o);

endmodule

`default_nettype wire

// File: ex_props.sv
`timescale 1ns/1ps
`default_nettype none

module ex_props (
	input logic                          clk,
	input logic                          rst_n_i,
	input logic [ex_pkg::aluop_w-1:0]    aluop_i,
	input logic                          stall_o,
	input logic                          whilo_o,
	input logic                          wreg_o,
	input logic [ex_pkg::exc_code_w-1:0] exc_code_o
);
	import ex_pkg::*;

	// only a division holds the pipe
	stall_only_div: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_o |-> (aluop_i == aluop_div || aluop_i == aluop_divu))
		else $error("stall raised without a division applied");

	// no hi/lo write before the quotient is there
	stall_no_whilo: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_o |-> !whilo_o)
		else $error("hi/lo write requested during a stall");

	ovf_no_wreg: assert property (@(posedge clk) disable iff (!rst_n_i)
		(exc_code_o == ec_ov) |-> !wreg_o) // overflow kills the gpr write
		else $error("register write kept on overflow");

endmodule

bind ex_stage ex_props u_props (.clk(clk), .rst_n_i(rst_n_i), .aluop_i(aluop_i),
	.stall_o(stall_o), .whilo_o(whilo_o), .wreg_o(wreg_o), .exc_code_o(exc_code_o));

`default_nettype wire

// File: tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
	import ex_pkg::*;

	localparam int n_ls  = 120; // logic and shift ops
	localparam int n_ar  = 120; // arithmetic and compare ops
	localparam int n_hl  = 80;  // hi/lo ops
	localparam int n_dv  = 24;  // divisions
	localparam int n_mem = 40;  // address and link ops
	localparam int n_ops = n_ls + n_ar + n_hl + n_dv + n_mem + 4;
	localparam int max_cycle = n_ops * 40; // a division needs about 35 cycles

	localparam logic [aluop_w-1:0] ls_ops [14] = '{aluop_and, aluop_or, aluop_xor, aluop_nor,
		aluop_andi, aluop_ori, aluop_xori, aluop_lui, aluop_sll, aluop_srl, aluop_sra,
		aluop_sllv, aluop_srlv, aluop_srav};
	localparam logic [aluop_w-1:0] ar_ops [10] = '{aluop_add, aluop_addu, aluop_sub, aluop_subu,
		aluop_slt, aluop_sltu, aluop_addi, aluop_addiu, aluop_slti, aluop_sltiu};
	localparam logic [aluop_w-1:0] hl_ops [6] = '{aluop_mult, aluop_multu, aluop_mthi,
		aluop_mtlo, aluop_mfhi, aluop_mflo};

	logic clk = 1'b0;
	logic rst_n_i;
	logic [alusel_w-1:0] alusel_i;
	logic [aluop_w-1:0] aluop_i;
	inst_u inst_i;
	logic [xlen-1:0] reg1_i, reg2_i, pc_i, link_addr_i, exc_epc_i;
	logic [reg_addr_w-1:0] wd_i, wd_o;
	logic wreg_i, in_delay_i, mem_whilo_i, wb_whilo_i;
	logic [xlen-1:0] hi_i, lo_i, mem_hi_i, mem_lo_i, wb_hi_i, wb_lo_i;
	logic [exc_code_w-1:0] exc_code_i, exc_code_o;
	logic wreg_o, whilo_o, stall_o;
	logic [xlen-1:0] wdata_o, hi_o, lo_o, mem_addr_o, exc_epc_o;
	int errors = 0;
	int cycles = 0;

	ex_stage dut0 (.*);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycle) begin
			$display("timeout, run did not finish within %0d cycles", max_cycle);
			$display("Testbench failed");
			$fatal(1, "cycle limit reached");
		end
	end

	//////////////////////////////////////////////////
	// compare tasks, first error ends the run

	task automatic abort_run();
		errors++;
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic word_eq(input string name, input logic [xlen-1:0] exp,
		input logic [xlen-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic pair_eq(input string name, input logic [2*xlen-1:0] exp,
		input logic [2*xlen-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic code_eq(input string name, input logic [exc_code_w-1:0] exp,
		input logic [exc_code_w-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic addr_eq(input string name, input logic [xlen-1:0] exp,
		input logic [xlen-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic index_eq(input string name, input logic [reg_addr_w-1:0] exp,
		input logic [reg_addr_w-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic flag_eq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// reference model

	function automatic logic [2*xlen-1:0] fwd_pair(); // newest hi:lo
		if (mem_whilo_i) return {mem_hi_i, mem_lo_i};
		else if (wb_whilo_i) return {wb_hi_i, wb_lo_i};
		return {hi_i, lo_i};
	endfunction

	function automatic logic [xlen-1:0] model_wdata();
		logic [4:0] sa;
		logic [xlen-1:0] fill; // sign bits shifted in by sra
		sa = (aluop_i inside {aluop_sllv, aluop_srlv, aluop_srav}) ? reg1_i[4:0]
			: inst_i.r_fmt.shamt;
		fill = reg2_i[xlen-1] ? ~(32'hffff_ffff >> sa) : 32'h0;
		if (alusel_i == alusel_branch) return link_addr_i;
		if (!(alusel_i inside {alusel_logic, alusel_shift, alusel_move, alusel_arith}))
			return 32'h0;
		case (aluop_i)
			aluop_and, aluop_andi: return reg1_i & reg2_i;
			aluop_or, aluop_ori:   return reg1_i | reg2_i;
			aluop_xor, aluop_xori: return reg1_i ^ reg2_i;
			aluop_nor:             return ~(reg1_i | reg2_i);
			aluop_lui:             return {inst_i.i_fmt.imm, 16'h0};
			aluop_sll, aluop_sllv: return reg2_i << sa;
			aluop_srl, aluop_srlv: return reg2_i >> sa;
			aluop_sra, aluop_srav: return (reg2_i >> sa) | fill;
			aluop_mfhi:            return fwd_pair() >> 32;
			aluop_mflo:            return fwd_pair() & 64'hffff_ffff;
			aluop_add, aluop_addu, aluop_addi, aluop_addiu: return reg1_i + reg2_i;
			aluop_sub, aluop_subu:   return reg1_i - reg2_i;
			aluop_slt, aluop_slti:   return {31'h0, $signed(reg1_i) < $signed(reg2_i)};
			aluop_sltu, aluop_sltiu: return {31'h0, reg1_i < reg2_i};
			default:                 return 32'h0;
		endcase
	endfunction

	// overflow when the wide result does not survive truncation to 32 bits
	function automatic logic model_ovf();
		logic signed [63:0] s;
		case (aluop_i)
			aluop_add, aluop_addi: s = longint'($signed(reg1_i)) + longint'($signed(reg2_i));
			aluop_sub:             s = longint'($signed(reg1_i)) - longint'($signed(reg2_i));
			default:               return 1'b0;
		endcase
		return s != longint'($signed(s[31:0]));
	endfunction

	function automatic logic [2*xlen-1:0] model_hilo();
		logic [2*xlen-1:0] cur;
		cur = fwd_pair();
		case (aluop_i)
			aluop_mult:  return 64'(longint'($signed(reg1_i)) * longint'($signed(reg2_i)));
			aluop_multu: return {32'h0, reg1_i} * {32'h0, reg2_i};
			aluop_mthi:  return {reg1_i, cur[xlen-1:0]};
			default:     return {cur[2*xlen-1:xlen], reg1_i}; // mtlo
		endcase
	endfunction

	//////////////////////////////////////////////////
	// stimulus

	task automatic shuffle_inputs();
		reg1_i      = $urandom;
		reg2_i      = $urandom;
		inst_i      = $urandom;
		pc_i        = $urandom & 32'hffff_fffc; // word aligned
		wd_i        = 5'($urandom);
		wreg_i      = 1'($urandom);
		in_delay_i  = 1'($urandom);
		link_addr_i = $urandom;
		hi_i        = $urandom;
		lo_i        = $urandom;
		mem_whilo_i = 1'($urandom);
		mem_hi_i    = $urandom;
		mem_lo_i    = $urandom;
		wb_whilo_i  = 1'($urandom);
		wb_hi_i     = $urandom;
		wb_lo_i     = $urandom;
		// earlier stage may flag one, overflow only arises here
		exc_code_i  = 1'($urandom) ? ec_none : 5'($urandom_range(11));
		exc_epc_i   = $urandom;
	endtask

	task automatic check_outputs(input string name);
		logic ov;
		ov = model_ovf();
		word_eq({name, " wdata"}, model_wdata(), wdata_o);
		index_eq({name, " wd"}, wd_i, wd_o);
		flag_eq({name, " wreg"}, wreg_i & ~ov, wreg_o);
		code_eq({name, " exc_code"}, ov ? ec_ov : exc_code_i, exc_code_o);
		word_eq({name, " exc_epc"}, ov ? (in_delay_i ? pc_i - 32'd4 : pc_i) : exc_epc_i,
			exc_epc_o);
		addr_eq({name, " mem_addr"}, (alusel_i == alusel_mem) ?
			reg1_i + {{16{inst_i.i_fmt.imm[15]}}, inst_i.i_fmt.imm} : 32'h0, mem_addr_o);
		if (aluop_i inside {aluop_mult, aluop_multu, aluop_mthi, aluop_mtlo}) begin
			flag_eq({name, " whilo"}, 1'b1, whilo_o);
			pair_eq({name, " hilo"}, model_hilo(), {hi_o, lo_o});
		end else begin
			flag_eq({name, " whilo"}, 1'b0, whilo_o);
		end
		flag_eq({name, " stall"}, 1'b0, stall_o);
	endtask

	// one op per cycle, driven on the falling edge
	task automatic issue_op(input string name, input logic [aluop_w-1:0] op,
		input logic [alusel_w-1:0] sel, input logic force_ov);
		@(negedge clk);
		shuffle_inputs();
		aluop_i  = op;
		alusel_i = sel;
		case (op) // immediates come in already extended
			aluop_andi, aluop_ori, aluop_xori: reg2_i = {16'h0, inst_i.i_fmt.imm};
			aluop_addi, aluop_addiu, aluop_slti, aluop_sltiu:
				reg2_i = {{16{inst_i.i_fmt.imm[15]}}, inst_i.i_fmt.imm};
			default: ;
		endcase
		if (force_ov) begin
			reg1_i = (reg1_i & 32'h7fff_ffff) | 32'h4000_0000; // both above 2^30
			reg2_i = (reg2_i & 32'h7fff_ffff) | 32'h4000_0000;
			if (op == aluop_sub) reg2_i = -reg2_i;
		end
		#10 check_outputs(name);
	endtask

	task automatic run_division(input logic [aluop_w-1:0] op);
		logic signed [63:0] q;
		logic signed [63:0] r;
		logic [2*xlen-1:0] exp;
		@(negedge clk);
		shuffle_inputs();
		aluop_i  = op;
		alusel_i = '0;
		wreg_i   = 1'b0;
		reg2_i   = $urandom >> $urandom_range(31); // spread of divisor sizes
		if (reg2_i == 0) reg2_i = 32'd3;
		if (op == aluop_div) begin
			q   = longint'($signed(reg1_i)) / longint'($signed(reg2_i));
			r   = longint'($signed(reg1_i)) % longint'($signed(reg2_i));
			exp = {r[31:0], q[31:0]};
		end else begin
			exp = {reg1_i % reg2_i, reg1_i / reg2_i};
		end
		#10 flag_eq("div stall rise", 1'b1, stall_o);
		do @(negedge clk); while (stall_o); // inputs held while stalled
		flag_eq("div whilo", 1'b1, whilo_o);
		pair_eq("div result", exp, {hi_o, lo_o});
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial begin
		void'($urandom(32'h71c9_f3df));
		rst_n_i = 1'b0;
		shuffle_inputs();
		aluop_i  = '0;
		alusel_i = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		#10 flag_eq("reset stall", 1'b0, stall_o);
		for (int i = 0; i < n_ls; i++) begin
			int k;
			k = $urandom_range(13);
			issue_op("logic_shift", ls_ops[k], (k < 8) ? alusel_logic : alusel_shift, 1'b0);
		end
		for (int i = 0; i < n_ar; i++) begin
			if (i % 4 == 0) issue_op("overflow", (i % 8 == 0) ? aluop_add : aluop_sub,
				alusel_arith, 1'b1);
			else issue_op("arith", ar_ops[$urandom_range(9)], alusel_arith, 1'b0);
		end
		for (int i = 0; i < n_hl; i++) begin
			logic [aluop_w-1:0] op;
			op = hl_ops[$urandom_range(5)];
			issue_op("hilo", op, (op inside {aluop_mfhi, aluop_mflo}) ? alusel_move : '0, 1'b0);
		end
		for (int i = 0; i < n_dv; i++) run_division((i % 2 == 0) ? aluop_div : aluop_divu);
		for (int i = 0; i < n_mem; i++)
			issue_op("mem_link", '0, 1'($urandom) ? alusel_mem : alusel_branch, 1'b0);
		@(negedge clk);
		if (errors == 0) $display("Testbench passed");
		else $display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
ex_pkg.sv
ex_logic_shift.sv
ex_arith.sv
ex_divider.sv
ex_hilo.sv
ex_result_sel.sv
ex_stage.sv
ex_props.sv
tb_ex_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ex_stage -f flist.f -o sim_ex

# the simulator exits non-zero on failure, the grep below decides
output=$(./obj_dir/sim_ex || true)
echo "$output"
if echo "$output" | grep -q "^Testbench passed$"; then
	exit 0
else
	exit 1
fi
